// ==== csr_defs_pkg.sv ====
`default_nettype none

package csr_defs_pkg;

    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // machine-mode CSRs held by the bank
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // same values as funct3 of the SYSTEM opcode
    typedef enum logic [2:0] {
        CSR_RW  = 3'b001,
        CSR_RS  = 3'b010,
        CSR_RC  = 3'b011,
        CSR_RWI = 3'b101,
        CSR_RSI = 3'b110,
        CSR_RCI = 3'b111
    } csr_op_e;

    // mtvec mode field in bits 1:0
    localparam logic [1:0] VEC_MODE_DIRECT   = 2'b00;
    localparam logic [1:0] VEC_MODE_VECTORED = 2'b01;

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // one CSR instruction from the issue port
    typedef struct packed {
        csr_defs_pkg::csr_addr_t addr;
        csr_defs_pkg::csr_op_e   op;
        csr_defs_pkg::csr_data_t operand;
        logic                    src_zero;
        logic [4:0]              rd;
    } csr_issue_t;

    // execute and cushion stage contents
    typedef struct packed {
        csr_defs_pkg::csr_addr_t addr;
        logic                    wr_en;
        csr_defs_pkg::csr_data_t new_val;
        csr_defs_pkg::csr_data_t old_val;
        logic [4:0]              rd;
    } csr_stage_t;

    typedef struct packed {
        logic                    en;
        csr_defs_pkg::csr_addr_t addr;
        csr_defs_pkg::csr_data_t data;
    } csr_fwd_t;

    // code bit 31 marks an interrupt
    typedef struct packed {
        csr_defs_pkg::csr_data_t code;
        csr_defs_pkg::csr_data_t pc;
    } trap_req_t;

    typedef struct packed {
        logic [4:0]              rd;
        csr_defs_pkg::csr_data_t old_val;
    } csr_result_t;

endpackage

`default_nettype wire

// ==== csr_alu.sv ====
`default_nettype none

module csr_alu (
    input  wire csr_defs_pkg::csr_op_e   op,
    input  wire csr_defs_pkg::csr_data_t old_val,
    input  wire csr_defs_pkg::csr_data_t operand,
    input  wire logic                    src_zero,
    output csr_defs_pkg::csr_data_t      new_val,
    output logic                         wr_en
);

    // operand already carries the zero-extended immediate for the I forms
    always_comb begin
        new_val = old_val;
        wr_en   = 1'b0;
        case (op)
            csr_defs_pkg::CSR_RW,
            csr_defs_pkg::CSR_RWI: begin
                new_val = operand;
                wr_en   = 1'b1;
            end
            csr_defs_pkg::CSR_RS,
            csr_defs_pkg::CSR_RSI: begin
                new_val = old_val | operand;
                // x0 or zero immediate must not write
                wr_en   = !src_zero;
            end
            csr_defs_pkg::CSR_RC,
            csr_defs_pkg::CSR_RCI: begin
                new_val = old_val & ~operand;
                wr_en   = !src_zero;
            end
            default: begin
                new_val = old_val;
                wr_en   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== csr_file.sv ====
`default_nettype none

module csr_file #(
    parameter csr_defs_pkg::csr_data_t RESET_VEC = 32'h0000_0000
) (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire logic                    hold,

    // read port for the R stage
    input  wire csr_defs_pkg::csr_addr_t rd_addr,
    output csr_defs_pkg::csr_data_t      rd_data,

    // fwd_c also acts as the write port
    input  wire pipe_pkg::csr_fwd_t      fwd_x,
    input  wire pipe_pkg::csr_fwd_t      fwd_c,

    input  wire logic                    trap_en,
    input  wire pipe_pkg::trap_req_t     trap,

    output csr_defs_pkg::csr_data_t      mtvec
);

    csr_defs_pkg::csr_data_t mtvec_r;
    csr_defs_pkg::csr_data_t mscratch_r;
    csr_defs_pkg::csr_data_t mepc_r;
    csr_defs_pkg::csr_data_t mcause_r;

    csr_defs_pkg::csr_data_t bank_rd;
    logic                    addr_hit;

    assign mtvec = mtvec_r;

    // unknown addresses read zero
    always_comb begin
        addr_hit = 1'b1;
        case (rd_addr)
            csr_defs_pkg::CSR_MTVEC:    bank_rd = mtvec_r;
            csr_defs_pkg::CSR_MSCRATCH: bank_rd = mscratch_r;
            csr_defs_pkg::CSR_MEPC:     bank_rd = mepc_r;
            csr_defs_pkg::CSR_MCAUSE:   bank_rd = mcause_r;
            default: begin
                bank_rd  = '0;
                addr_hit = 1'b0;
            end
        endcase
    end

    // younger X entry wins over C and C over the bank
    always_comb begin
        if (!addr_hit) begin
            rd_data = '0;
        end
        else if (fwd_x.en && fwd_x.addr == rd_addr) begin
            rd_data = fwd_x.data;
        end
        else if (fwd_c.en && fwd_c.addr == rd_addr) begin
            rd_data = fwd_c.data;
        end
        else begin
            rd_data = bank_rd;
        end
    end

    // trap beats the cushion commit and hold blocks both
    always_ff @(posedge CLK) begin
        if (RST) begin
            mtvec_r    <= RESET_VEC;
            mscratch_r <= '0;
            mepc_r     <= '0;
            mcause_r   <= '0;
        end
        else if (trap_en) begin
            mepc_r   <= trap.pc;
            mcause_r <= trap.code;
        end
        else if (!hold && fwd_c.en) begin
            case (fwd_c.addr)
                csr_defs_pkg::CSR_MTVEC:    mtvec_r    <= fwd_c.data;
                csr_defs_pkg::CSR_MSCRATCH: mscratch_r <= fwd_c.data;
                csr_defs_pkg::CSR_MEPC:     mepc_r     <= fwd_c.data;
                csr_defs_pkg::CSR_MCAUSE:   mcause_r   <= fwd_c.data;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== csr_pipe.sv ====
`default_nettype none

module csr_pipe (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire logic                    hold,
    input  wire logic                    flush,

    input  wire logic                    issue_valid,
    input  wire pipe_pkg::csr_issue_t    issue,

    // R stage payload and what the read/ALU made of it
    output pipe_pkg::csr_issue_t         r_op,
    input  wire csr_defs_pkg::csr_data_t r_old,
    input  wire csr_defs_pkg::csr_data_t r_new,
    input  wire logic                    r_wr_en,

    output pipe_pkg::csr_fwd_t           fwd_x,
    output pipe_pkg::csr_fwd_t           fwd_c,

    output logic                         result_valid,
    output pipe_pkg::csr_result_t        result
);

    logic                 r_valid;
    logic                 x_valid;
    logic                 c_valid;
    pipe_pkg::csr_stage_t x_q;
    pipe_pkg::csr_stage_t c_q;

    // flush also drops an issue arriving on the same edge
    always_ff @(posedge CLK) begin
        if (RST || flush) begin
            r_valid <= 1'b0;
            x_valid <= 1'b0;
            c_valid <= 1'b0;
        end
        else if (!hold) begin
            r_valid <= issue_valid;
            x_valid <= r_valid;
            c_valid <= x_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold) begin
            r_op        <= issue;
            x_q.addr    <= r_op.addr;
            x_q.wr_en   <= r_wr_en;
            x_q.new_val <= r_new;
            x_q.old_val <= r_old;
            x_q.rd      <= r_op.rd;
            c_q         <= x_q;
        end
    end

    assign fwd_x = '{en: x_valid && x_q.wr_en, addr: x_q.addr, data: x_q.new_val};
    assign fwd_c = '{en: c_valid && c_q.wr_en, addr: c_q.addr, data: c_q.new_val};

    assign result_valid = x_valid;
    assign result       = '{rd: x_q.rd, old_val: x_q.old_val};

endmodule

`default_nettype wire

// ==== trap_ctrl.sv ====
`default_nettype none

module trap_ctrl (
    input  wire logic                    CLK,
    input  wire logic                    RST,
    input  wire logic                    hold,

    input  wire logic                    trap_valid,
    input  wire pipe_pkg::trap_req_t     trap,
    input  wire csr_defs_pkg::csr_data_t mtvec,

    output logic                         trap_en,
    output logic                         flush,

    output logic                         redirect_valid,
    output csr_defs_pkg::csr_data_t      redirect_pc
);

    csr_defs_pkg::csr_data_t vec_base;
    csr_defs_pkg::csr_data_t target;

    // no trap is taken while held
    assign trap_en = trap_valid && !hold;
    assign flush   = trap_en;

    assign vec_base = {mtvec[31:2], 2'b00};

    // interrupts in vectored mode jump to base + 4*cause
    always_comb begin
        if (mtvec[1:0] == csr_defs_pkg::VEC_MODE_VECTORED && trap.code[31]) begin
            target = vec_base + {trap.code[29:0], 2'b00};
        end
        else begin
            target = vec_base;
        end
    end

    // one-cycle pulse as trap_en is low during hold
    always_ff @(posedge CLK) begin
        if (RST) begin
            redirect_valid <= 1'b0;
        end
        else begin
            redirect_valid <= trap_en;
        end
    end

    always_ff @(posedge CLK) begin
        if (trap_en) begin
            redirect_pc <= target;
        end
    end

endmodule

`default_nettype wire

// ==== csr_unit_top.sv ====
`default_nettype none

module csr_unit_top #(
    parameter csr_defs_pkg::csr_data_t RESET_VEC = 32'h0000_1000
) (
    input  wire logic                 CLK,
    input  wire logic                 RST,

    input  wire logic                 issue_valid,
    input  wire pipe_pkg::csr_issue_t issue,
    input  wire logic                 hold,

    input  wire logic                 trap_valid,
    input  wire pipe_pkg::trap_req_t  trap,

    output logic                      result_valid,
    output pipe_pkg::csr_result_t     result,

    output logic                      redirect_valid,
    output csr_defs_pkg::csr_data_t   redirect_pc
);

    pipe_pkg::csr_issue_t    r_op;
    csr_defs_pkg::csr_data_t r_old;
    csr_defs_pkg::csr_data_t r_new;
    logic                    r_wr_en;
    pipe_pkg::csr_fwd_t      fwd_x;
    pipe_pkg::csr_fwd_t      fwd_c;
    logic                    trap_en;
    logic                    flush;
    csr_defs_pkg::csr_data_t mtvec;

    csr_pipe u_pipe (
        .CLK          (CLK),
        .RST          (RST),
        .hold         (hold),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .r_op         (r_op),
        .r_old        (r_old),
        .r_new        (r_new),
        .r_wr_en      (r_wr_en),
        .fwd_x        (fwd_x),
        .fwd_c        (fwd_c),
        .result_valid (result_valid),
        .result       (result)
    );

    csr_file #(
        .RESET_VEC (RESET_VEC)
    ) u_file (
        .CLK     (CLK),
        .RST     (RST),
        .hold    (hold),
        .rd_addr (r_op.addr),
        .rd_data (r_old),
        .fwd_x   (fwd_x),
        .fwd_c   (fwd_c),
        .trap_en (trap_en),
        .trap    (trap),
        .mtvec   (mtvec)
    );

    csr_alu u_alu (
        .op       (r_op.op),
        .old_val  (r_old),
        .operand  (r_op.operand),
        .src_zero (r_op.src_zero),
        .new_val  (r_new),
        .wr_en    (r_wr_en)
    );

    trap_ctrl u_trap (
        .CLK            (CLK),
        .RST            (RST),
        .hold           (hold),
        .trap_valid     (trap_valid),
        .trap           (trap),
        .mtvec          (mtvec),
        .trap_en        (trap_en),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== tb_csr_unit.sv ====
`default_nettype none

module tb_csr_unit;

    // vectored mode from reset
    localparam logic [31:0] RESET_VEC    = 32'h8000_0101;
    localparam int          PERIOD       = 4;
    localparam int          RAND_CYCLES  = 4000;
    localparam int          FIXED_CYCLES = 60;
    localparam int          TIMEOUT      = (RAND_CYCLES + FIXED_CYCLES + 200) * PERIOD;

    typedef struct packed {
        logic        valid;
        logic        wr;
        logic        impl;
        logic [1:0]  idx;
        logic [31:0] new_val;
        logic [31:0] old_val;
        logic [4:0]  rd;
    } shadow_t;

    logic                    CLK;
    logic                    RST;
    logic                    issue_valid;
    pipe_pkg::csr_issue_t    issue;
    logic                    hold;
    logic                    trap_valid;
    pipe_pkg::trap_req_t     trap;
    logic                    result_valid;
    pipe_pkg::csr_result_t   result;
    logic                    redirect_valid;
    csr_defs_pkg::csr_data_t redirect_pc;

    integer      seed = 77850;
    integer      errors = 0;
    integer      dut_results = 0;
    integer      model_results = 0;
    integer      traps_taken = 0;
    // slots in order mtvec, mscratch, mepc, mcause
    logic [31:0] arch [4];
    logic [31:0] spec [4];
    shadow_t     sh_r;
    shadow_t     sh_x;
    shadow_t     sh_c;
    logic        exp_redir_v;
    logic [31:0] exp_redir_pc;
    logic        moved;

    csr_unit_top #(
        .RESET_VEC (RESET_VEC)
    ) dut0 (
        .CLK            (CLK),
        .RST            (RST),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .hold           (hold),
        .trap_valid     (trap_valid),
        .trap           (trap),
        .result_valid   (result_valid),
        .result         (result),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #(PERIOD / 2) CLK = ~CLK;

    initial begin
        #(TIMEOUT);
        $display("timeout: run did not reach its end within %0d time units", TIMEOUT);
        $display("Simulation failed");
        $finish;
    end

    function automatic int slot_of(input csr_defs_pkg::csr_addr_t addr);
        case (addr)
            csr_defs_pkg::CSR_MTVEC:    return 0;
            csr_defs_pkg::CSR_MSCRATCH: return 1;
            csr_defs_pkg::CSR_MEPC:     return 2;
            csr_defs_pkg::CSR_MCAUSE:   return 3;
            default:                    return -1;
        endcase
    endfunction

    // {write enable, new value}
    function automatic logic [32:0] csr_update(input csr_defs_pkg::csr_op_e op,
                                               input logic [31:0] old_val,
                                               input logic [31:0] operand,
                                               input logic src_zero);
        case (op)
            csr_defs_pkg::CSR_RW, csr_defs_pkg::CSR_RWI: return {1'b1, operand};
            csr_defs_pkg::CSR_RS, csr_defs_pkg::CSR_RSI: return {!src_zero, old_val | operand};
            csr_defs_pkg::CSR_RC, csr_defs_pkg::CSR_RCI: return {!src_zero, old_val & ~operand};
            default:                                     return {1'b0, old_val};
        endcase
    endfunction

    function automatic logic [31:0] redirect_target(input logic [31:0] tvec,
                                                    input logic [31:0] code);
        logic [31:0] base;
        base = {tvec[31:2], 2'b00};
        if (tvec[1:0] == csr_defs_pkg::VEC_MODE_VECTORED && code[31]) begin
            return base + ((code & 32'h7fff_ffff) << 2);
        end
        return base;
    endfunction

    // in-order model plus shadow of the R, X and C stages
    always @(posedge CLK) begin : model_step
        int          slot;
        logic [32:0] upd;
        exp_redir_v = 1'b0;
        moved       = 1'b0;
        if (RST) begin
            arch = '{RESET_VEC, 32'h0, 32'h0, 32'h0};
            spec = arch;
            sh_r = '0;
            sh_x = '0;
            sh_c = '0;
        end
        else if (!hold) begin
            moved = 1'b1;
            if (trap_valid) begin
                exp_redir_v  = 1'b1;
                exp_redir_pc = redirect_target(arch[0], trap.code);
                arch[2]      = trap.pc;
                arch[3]      = trap.code;
                spec         = arch;
                sh_r         = '0;
                sh_x         = '0;
                sh_c         = '0;
                traps_taken++;
            end
            else begin
                if (sh_c.valid && sh_c.wr && sh_c.impl) begin
                    arch[sh_c.idx] = sh_c.new_val;
                end
                sh_c = sh_x;
                sh_x = sh_r;
                sh_r = '0;
                if (sh_x.valid) begin
                    model_results++;
                end
                if (issue_valid) begin
                    slot         = slot_of(issue.addr);
                    sh_r.valid   = 1'b1;
                    sh_r.rd      = issue.rd;
                    sh_r.impl    = slot >= 0;
                    sh_r.idx     = slot[1:0];
                    sh_r.old_val = sh_r.impl ? spec[sh_r.idx] : 32'h0;
                    upd = csr_update(issue.op, sh_r.old_val, issue.operand, issue.src_zero);
                    sh_r.wr      = upd[32];
                    sh_r.new_val = upd[31:0];
                    if (sh_r.wr && sh_r.impl) begin
                        spec[sh_r.idx] = sh_r.new_val;
                    end
                end
            end
        end
    end

    task automatic check_outputs();
        if (result_valid !== sh_x.valid) begin
            $display("FAILED result_valid expected %h got %h", sh_x.valid, result_valid);
            errors++;
        end
        else if (sh_x.valid) begin
            if (result.rd !== sh_x.rd) begin
                $display("FAILED result.rd expected %h got %h", sh_x.rd, result.rd);
                errors++;
            end
            if (result.old_val !== sh_x.old_val) begin
                $display("FAILED result.old_val expected %h got %h", sh_x.old_val,
                         result.old_val);
                errors++;
            end
        end
        if (moved && result_valid === 1'b1) begin
            dut_results++;
        end
        if (redirect_valid !== exp_redir_v) begin
            $display("FAILED redirect_valid expected %h got %h", exp_redir_v, redirect_valid);
            errors++;
        end
        else if (exp_redir_v && redirect_pc !== exp_redir_pc) begin
            $display("FAILED redirect_pc expected %h got %h", exp_redir_pc, redirect_pc);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(negedge CLK);
        check_outputs();
    endtask

    task automatic send(input csr_defs_pkg::csr_op_e op, input csr_defs_pkg::csr_addr_t addr,
                        input logic [31:0] operand, input logic [4:0] rd);
        issue       = '{addr: addr, op: op, operand: operand, src_zero: operand == 32'h0,
                        rd: rd};
        issue_valid = 1'b1;
        hold        = 1'b0;
        trap_valid  = 1'b0;
        next_cycle();
        issue_valid = 1'b0;
    endtask

    // zero-source reads of every CSR and of two unimplemented addresses
    task automatic readback_all();
        send(csr_defs_pkg::CSR_RS, csr_defs_pkg::CSR_MTVEC, 32'h0, 5'd1);
        send(csr_defs_pkg::CSR_RS, csr_defs_pkg::CSR_MSCRATCH, 32'h0, 5'd2);
        send(csr_defs_pkg::CSR_RS, csr_defs_pkg::CSR_MEPC, 32'h0, 5'd3);
        send(csr_defs_pkg::CSR_RS, csr_defs_pkg::CSR_MCAUSE, 32'h0, 5'd4);
        send(csr_defs_pkg::CSR_RS, 12'h300, 32'h0, 5'd5);
        send(csr_defs_pkg::CSR_RS, 12'hfff, 32'h0, 5'd6);
    endtask

    task automatic idle_cycles(input int n);
        issue_valid = 1'b0;
        hold        = 1'b0;
        trap_valid  = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic random_cycle();
        logic [31:0]           r;
        csr_defs_pkg::csr_op_e op;
        r = $random(seed);
        hold = (r % 100) < 15;
        r = $random(seed);
        trap_valid = (r % 100) < 4;
        r = $random(seed);
        issue_valid = (r % 100) < 70;
        r = $random(seed);
        // unimplemented addresses come from a small set so they repeat in flight
        case (r % 8)
            0, 1:    issue.addr = csr_defs_pkg::CSR_MTVEC;
            2, 3:    issue.addr = csr_defs_pkg::CSR_MSCRATCH;
            4:       issue.addr = csr_defs_pkg::CSR_MEPC;
            5, 6:    issue.addr = csr_defs_pkg::CSR_MCAUSE;
            default: issue.addr = 12'h300 | {10'h0, r[13:12]};
        endcase
        r = $random(seed);
        case (r % 6)
            0:       op = csr_defs_pkg::CSR_RW;
            1:       op = csr_defs_pkg::CSR_RS;
            2:       op = csr_defs_pkg::CSR_RC;
            3:       op = csr_defs_pkg::CSR_RWI;
            4:       op = csr_defs_pkg::CSR_RSI;
            default: op = csr_defs_pkg::CSR_RCI;
        endcase
        issue.op = op;
        r = $random(seed);
        // immediate forms get a 5-bit value that is zero about a quarter of the time
        if (op == csr_defs_pkg::CSR_RWI || op == csr_defs_pkg::CSR_RSI ||
            op == csr_defs_pkg::CSR_RCI) begin
            issue.operand = (r[7:6] == 2'b00) ? 32'h0 : {27'h0, r[4:0]};
        end
        else begin
            issue.operand = (r[2:0] == 3'b000) ? 32'h0 : $random(seed);
        end
        issue.src_zero = issue.operand == 32'h0;
        r = $random(seed);
        issue.rd   = r[4:0];
        trap.code  = $random(seed);
        r = $random(seed);
        trap.pc    = r & 32'hffff_fffc;
        next_cycle();
    endtask

    initial begin
        CLK         = 1'b0;
        RST         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        hold        = 1'b0;
        trap_valid  = 1'b0;
        trap        = '0;
        repeat (3) @(negedge CLK);
        RST = 1'b0;
        readback_all();
        // back-to-back ops on mscratch use both forward stages
        send(csr_defs_pkg::CSR_RW, csr_defs_pkg::CSR_MSCRATCH, 32'h1234_5678, 5'd7);
        send(csr_defs_pkg::CSR_RS, csr_defs_pkg::CSR_MSCRATCH, 32'h0000_00f0, 5'd8);
        send(csr_defs_pkg::CSR_RW, csr_defs_pkg::CSR_MEPC, 32'hdead_beef, 5'd9);
        send(csr_defs_pkg::CSR_RCI, csr_defs_pkg::CSR_MSCRATCH, 32'h0000_0018, 5'd10);
        send(csr_defs_pkg::CSR_RSI, csr_defs_pkg::CSR_MSCRATCH, 32'h0, 5'd11);
        // interrupt lands while the last three are still in flight
        trap.code  = 32'h8000_0007;
        trap.pc    = 32'h0000_2000;
        trap_valid = 1'b1;
        next_cycle();
        trap_valid = 1'b0;
        readback_all();
        repeat (RAND_CYCLES) random_cycle();
        idle_cycles(6);
        readback_all();
        idle_cycles(6);
        if (dut_results != model_results) begin
            $display("result count mismatch: DUT gave %0d results, model expects %0d",
                     dut_results, model_results);
            errors++;
        end
        $display("errors: %0d  results: %0d  traps: %0d", errors, dut_results, traps_taken);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
csr_defs_pkg.sv
pipe_pkg.sv
csr_alu.sv
csr_file.sv
csr_pipe.sv
trap_ctrl.sv
csr_unit_top.sv
tb_csr_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_csr_unit -o sim_csr_unit > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_csr_unit > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
fi

echo "FAIL, see sim.log"
exit 1
